// ==== Bender.yml ====
package:
  name: periph_bus

sources:
  # design sources, the package first.
  - include_dirs:
      - design
    files:
      - design/periph_bus_pkg.sv
      - design/periph_apb_decode.sv
      - design/gpio_regs.sv
      - design/tick_timer.sv
      - design/periph_bus_top.sv

  # dv sources.
  - target: test
    include_dirs:
      - design
    files:
      - dv/tb_clk_gen.sv
      - dv/tb_periph_bus.sv

// ==== design/gpio_regs.sv ====
`timescale 1ns/1ps
`include "periph_bus_defs.svh"

module gpio_regs
    import periph_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       sel_i,
    input  logic       penable_i,
    input  logic       wr_i,
    input  reg_off_t   off_i,
    input  bus_word_t  wdata_i,
    input  byte_strb_t strb_i,
    input  bus_word_t  gpio_in_i,
    output bus_word_t  rdata_o,
    output logic       ready_o,
    output bus_word_t  gpio_out_o,
    output bus_word_t  gpio_dir_o
);

    bus_word_t out_q;
    bus_word_t dir_q;
    bus_word_t in_meta_q;
    bus_word_t in_sync_q;
    logic      access;
    logic      wr_en;

    assign access  = sel_i && penable_i;
    assign wr_en   = access && wr_i;
    assign ready_o = access; // no wait states.

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_q <= '0;
            dir_q <= '0;
        end else if (wr_en) begin
            case (off_i)
                `PB_GPIO_OUT: out_q <= strb_merge(out_q, wdata_i, strb_i);
                `PB_GPIO_DIR: dir_q <= strb_merge(dir_q, wdata_i, strb_i);
                default: ; // the input register and holes ignore writes.
            endcase
        end
    end

    // two-flop synchronizer on the pins.
    always_ff @(posedge clk) begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    always_comb begin
        case (off_i)
            `PB_GPIO_OUT: rdata_o = out_q;
            `PB_GPIO_DIR: rdata_o = dir_q;
            `PB_GPIO_IN:  rdata_o = in_sync_q;
            default:      rdata_o = '0;
        endcase
    end

    assign gpio_out_o = out_q;
    assign gpio_dir_o = dir_q;

endmodule

// ==== design/periph_apb_decode.sv ====
`timescale 1ns/1ps
`include "periph_bus_defs.svh"

module periph_apb_decode
    import periph_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  bus_word_t  pwdata_i,
    input  byte_strb_t pstrb_i,
    input  bus_word_t  gpio_rdata_i,
    input  bus_word_t  tick_rdata_i,
    input  logic       gpio_ready_i,
    input  logic       tick_ready_i,
    output bus_word_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    output logic       gpio_sel_o,
    output logic       tick_sel_o,
    output reg_off_t   off_o,
    output logic       wr_o,
    output bus_word_t  wdata_o,
    output byte_strb_t strb_o
);

    localparam apb_addr_t GPIO_BASE = `PB_GPIO_BASE;
    localparam apb_addr_t TICK_BASE = `PB_TICK_BASE;

    logic [`PB_ADDR_W-`PB_OFF_W-1:0] win;
    logic gpio_hit;
    logic tick_hit;

    // ##########################################################
    // address split and select
    // ##########################################################
    assign win      = paddr_i[`PB_ADDR_W-1:`PB_OFF_W];
    assign gpio_hit = (win == GPIO_BASE[`PB_ADDR_W-1:`PB_OFF_W]);
    assign tick_hit = (win == TICK_BASE[`PB_ADDR_W-1:`PB_OFF_W]);

    assign gpio_sel_o = psel_i && gpio_hit; // held through setup and access.
    assign tick_sel_o = psel_i && tick_hit;

    assign off_o   = paddr_i[`PB_OFF_W-1:0];
    assign wr_o    = pwrite_i;
    assign wdata_o = pwdata_i;
    assign strb_o  = pstrb_i;

    // ##########################################################
    // response mux
    // ##########################################################
    always_comb begin
        pready_o  = 1'b0;
        pslverr_o = 1'b0;
        prdata_o  = '0;
        if (psel_i && penable_i) begin
            if (gpio_sel_o) begin
                pready_o = gpio_ready_i;
                prdata_o = gpio_rdata_i;
            end else if (tick_sel_o) begin
                pready_o = tick_ready_i;
                prdata_o = tick_rdata_i;
            end else begin
                pready_o  = 1'b1; // unmapped window errors out at once.
                pslverr_o = 1'b1;
            end
        end
    end

    // the map never lets both windows claim the same address.
    a_one_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0({gpio_sel_o, tick_sel_o}));

    a_err_no_sel: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(pslverr_o) |-> !gpio_sel_o && !tick_sel_o);

endmodule

// ==== design/periph_bus_defs.svh ====
`ifndef PERIPH_BUS_DEFS_SVH
`define PERIPH_BUS_DEFS_SVH

// bus widths.
`define PB_ADDR_W 12
`define PB_DATA_W 32
`define PB_OFF_W 8

// address map, each peripheral owns a 256-byte window.
`define PB_GPIO_BASE 12'h000
`define PB_TICK_BASE 12'h100

`define PB_GPIO_OUT 8'h00 // output value.
`define PB_GPIO_DIR 8'h04 // direction, 1 drives the pin.
`define PB_GPIO_IN 8'h08 // synchronized pins, read only.

`define PB_TICK_COUNT 8'h00
`define PB_TICK_CMP 8'h04
`define PB_TICK_CTRL 8'h08 // bit 0 enables counting.
`define PB_TICK_STAT 8'h0C // bit 0 is the hit flag, write 1 to clear.

`define PB_TICK_DIV 4 // bus clocks per timer count.

`endif

// ==== design/periph_bus_pkg.sv ====
`include "periph_bus_defs.svh"

package periph_bus_pkg;

    typedef logic [`PB_ADDR_W-1:0] apb_addr_t; // bus address.
    typedef logic [`PB_DATA_W-1:0] bus_word_t; // data word.
    typedef logic [`PB_DATA_W/8-1:0] byte_strb_t; // one bit per byte lane.
    typedef logic [`PB_OFF_W-1:0] reg_off_t; // offset inside a window.

    // Replaces the bytes of old_w whose strobe bit is set.
    function automatic bus_word_t strb_merge(
        input bus_word_t old_w,
        input bus_word_t new_w,
        input byte_strb_t strb
    );
        bus_word_t res;
        res = old_w;
        for (int i = 0; i < `PB_DATA_W/8; i++) begin
            if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
        end
        return res;
    endfunction

endpackage

// ==== design/periph_bus_top.sv ====
`timescale 1ns/1ps

module periph_bus_top
    import periph_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       psel_i,
    input  logic       penable_i,
    input  logic       pwrite_i,
    input  apb_addr_t  paddr_i,
    input  bus_word_t  pwdata_i,
    input  byte_strb_t pstrb_i,
    output bus_word_t  prdata_o,
    output logic       pready_o,
    output logic       pslverr_o,
    input  bus_word_t  gpio_in_i,
    output bus_word_t  gpio_out_o,
    output bus_word_t  gpio_dir_o,
    output logic       irq_o
);

    bus_word_t  gpio_rdata;
    bus_word_t  tick_rdata;
    bus_word_t  wdata;
    byte_strb_t strb;
    reg_off_t   off;
    logic       gpio_ready;
    logic       tick_ready;
    logic       gpio_sel;
    logic       tick_sel;
    logic       wr;

    periph_apb_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .pstrb_i     (pstrb_i),
        .gpio_rdata_i(gpio_rdata),
        .tick_rdata_i(tick_rdata),
        .gpio_ready_i(gpio_ready),
        .tick_ready_i(tick_ready),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .gpio_sel_o  (gpio_sel),
        .tick_sel_o  (tick_sel),
        .off_o       (off),
        .wr_o        (wr),
        .wdata_o     (wdata),
        .strb_o      (strb)
    );

    gpio_regs u_gpio (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .sel_i     (gpio_sel),
        .penable_i (penable_i),
        .wr_i      (wr),
        .off_i     (off),
        .wdata_i   (wdata),
        .strb_i    (strb),
        .gpio_in_i (gpio_in_i),
        .rdata_o   (gpio_rdata),
        .ready_o   (gpio_ready),
        .gpio_out_o(gpio_out_o),
        .gpio_dir_o(gpio_dir_o)
    );

    tick_timer u_tick (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .sel_i    (tick_sel),
        .penable_i(penable_i),
        .wr_i     (wr),
        .off_i    (off),
        .wdata_i  (wdata),
        .strb_i   (strb),
        .rdata_o  (tick_rdata),
        .ready_o  (tick_ready),
        .irq_o    (irq_o)
    );

endmodule

// ==== design/tick_timer.sv ====
`timescale 1ns/1ps
`include "periph_bus_defs.svh"

module tick_timer
    import periph_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       sel_i,
    input  logic       penable_i,
    input  logic       wr_i,
    input  reg_off_t   off_i,
    input  bus_word_t  wdata_i,
    input  byte_strb_t strb_i,
    output bus_word_t  rdata_o,
    output logic       ready_o,
    output logic       irq_o
);

    localparam int DIV_W = (`PB_TICK_DIV > 1) ? $clog2(`PB_TICK_DIV) : 1;
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`PB_TICK_DIV - 1);

    logic [DIV_W-1:0] div_q;
    bus_word_t        count_q;
    bus_word_t        cmp_q;
    bus_word_t        count_inc;
    logic             en_q;
    logic             hit_q;
    logic             irq_q;
    logic             pend_q;
    logic             access;
    logic             wr_en;
    logic             count_adv;
    logic             count_wr;
    logic             stat_clr;

    // ##########################################################
    // bus side, one wait state per access
    // ##########################################################
    assign access  = sel_i && penable_i;
    assign ready_o = access && pend_q;
    assign wr_en   = ready_o && wr_i; // writes land on the completing edge.

    always_ff @(posedge clk) begin
        if (!rst_n_i) pend_q <= 1'b0;
        else          pend_q <= access && !pend_q;
    end

    assign count_wr = wr_en && (off_i == `PB_TICK_COUNT);
    assign stat_clr = wr_en && (off_i == `PB_TICK_STAT) && strb_i[0] && wdata_i[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            cmp_q <= '0;
            en_q  <= 1'b0;
        end else if (wr_en) begin
            if (off_i == `PB_TICK_CMP) cmp_q <= strb_merge(cmp_q, wdata_i, strb_i);
            if (off_i == `PB_TICK_CTRL && strb_i[0]) en_q <= wdata_i[0];
        end
    end

    // ##########################################################
    // prescaler, counter and compare
    // ##########################################################
    assign count_adv = en_q && (div_q == DIV_LAST);
    assign count_inc = count_q + 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n_i || !en_q) div_q <= '0;
        else                   div_q <= count_adv ? '0 : div_q + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            count_q <= '0;
            hit_q   <= 1'b0;
            irq_q   <= 1'b0;
        end else begin
            if (count_wr)       count_q <= strb_merge(count_q, wdata_i, strb_i);
            else if (count_adv) count_q <= count_inc;
            if (count_adv && !count_wr && count_inc == cmp_q) hit_q <= 1'b1; // set beats clear.
            else if (stat_clr)                                  hit_q <= 1'b0;
            irq_q <= hit_q;
        end
    end

    always_comb begin
        case (off_i)
            `PB_TICK_COUNT: rdata_o = count_q;
            `PB_TICK_CMP:   rdata_o = cmp_q;
            `PB_TICK_CTRL:  rdata_o = bus_word_t'(en_q);
            `PB_TICK_STAT:  rdata_o = bus_word_t'(hit_q);
            default:        rdata_o = '0;
        endcase
    end

    assign irq_o = irq_q;

    // ready only closes an access that was already open the cycle before.
    a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        ready_o |-> access && $past(access));

    a_irq_fall: assert property (@(posedge clk) disable iff (!rst_n_i)
        $fell(irq_o) |-> $past(stat_clr, 2));

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o; // 8 ns period.
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        rst_n_o <= 1'b1; // released on a rising edge.
    end

endmodule

// ==== dv/tb_periph_bus.sv ====
`timescale 1ns/1ps
`include "periph_bus_defs.svh"

module tb_periph_bus
    import periph_bus_pkg::*;
();

    localparam int LIMIT = 100; // cycles that any wait may take.
    localparam logic [1:0] CHK_NONE = 2'd0;
    localparam logic [1:0] CHK_EQ = 2'd1;
    localparam logic [1:0] CHK_UP = 2'd2; // count reads, rising and moved off the load.
    localparam apb_addr_t OUT_A = `PB_GPIO_BASE | `PB_GPIO_OUT;
    localparam apb_addr_t DIR_A = `PB_GPIO_BASE | `PB_GPIO_DIR;
    localparam apb_addr_t IN_A = `PB_GPIO_BASE | `PB_GPIO_IN;
    localparam apb_addr_t COUNT_A = `PB_TICK_BASE | `PB_TICK_COUNT;
    localparam apb_addr_t CMP_A = `PB_TICK_BASE | `PB_TICK_CMP;
    localparam apb_addr_t CTRL_A = `PB_TICK_BASE | `PB_TICK_CTRL;
    localparam apb_addr_t STAT_A = `PB_TICK_BASE | `PB_TICK_STAT;

    logic       clk;
    logic       rst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    apb_addr_t  paddr;
    bus_word_t  pwdata;
    byte_strb_t pstrb;
    bus_word_t  prdata_o;
    logic       pready_o;
    logic       pslverr_o;
    bus_word_t  gpio_in;
    bus_word_t  gpio_out_o;
    bus_word_t  gpio_dir_o;
    logic       irq_o;
    bus_word_t  m_out;
    bus_word_t  m_dir;
    bus_word_t  exp_rdata;
    bus_word_t  avoid_rdata;
    logic [1:0] chk_mode;
    logic       irq_chk;
    bus_word_t  rng;
    int         mism_cnt;
    int         tmo_cnt;
    logic [3:0] win;
    logic       done;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    periph_bus_top DUT (
        .clk(clk), .rst_n_i(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
        .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_o(prdata_o),
        .pready_o(pready_o), .pslverr_o(pslverr_o), .gpio_in_i(gpio_in),
        .gpio_out_o(gpio_out_o), .gpio_dir_o(gpio_dir_o), .irq_o(irq_o)
    );

    assign win  = paddr[`PB_ADDR_W-1:8]; // 0 is GPIO, 1 is the timer.
    assign done = psel && penable && pready_o;

    task automatic report_mismatch(input string msg);
        mism_cnt++;
        $display("Mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_timeout(input string what);
        tmo_cnt++;
        $display("Timed out at %0t while waiting for %s", $time, what);
    endtask

    function automatic bus_word_t apply_strobes(input bus_word_t old_w, input bus_word_t new_w,
                                                input byte_strb_t strb);
        bus_word_t mask;
        for (int i = 0; i < 4; i++) mask[8*i +: 8] = {8{strb[i]}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic bus_word_t xorshift32(input bus_word_t x);
        bus_word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // ##########################################################
    // checks
    // ##########################################################
    a_read_eq: assert property (@(posedge clk) disable iff (!rst_n)
        done && !pwrite && chk_mode == CHK_EQ |-> prdata_o == exp_rdata)
        else report_mismatch("read data differs from the model");
    a_read_up: assert property (@(posedge clk) disable iff (!rst_n)
        done && chk_mode == CHK_UP |-> prdata_o >= exp_rdata && prdata_o != avoid_rdata)
        else report_mismatch("count went down or did not move off the loaded value");
    a_gpio_pins: assert property (@(posedge clk) disable iff (!rst_n)
        gpio_out_o == m_out && gpio_dir_o == m_dir)
        else report_mismatch("gpio output or direction pins differ from the model");
    a_gpio_ready: assert property (@(posedge clk) disable iff (!rst_n)
        psel && penable && win == 0 |-> pready_o)
        else report_mismatch("gpio access did not finish in its first access cycle");
    a_tick_wait: assert property (@(posedge clk) disable iff (!rst_n)
        psel && $rose(penable) && win == 1 |-> !pready_o ##1 pready_o)
        else report_mismatch("timer access did not take exactly one wait state");
    a_unmapped: assert property (@(posedge clk) disable iff (!rst_n)
        done && win > 1 |-> pslverr_o && prdata_o == '0)
        else report_mismatch("unmapped access without error or with read data");
    a_mapped: assert property (@(posedge clk) disable iff (!rst_n)
        done && win < 2 |-> !pslverr_o)
        else report_mismatch("mapped access returned an error");
    a_irq: assert property (@(posedge clk) disable iff (!rst_n) irq_chk |-> !irq_o)
        else report_mismatch("irq_o is high while no compare hit is pending");

    // ##########################################################
    // APB transfers
    // ##########################################################
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input bus_word_t data,
                            input byte_strb_t strb, input logic [1:0] mode,
                            input bus_word_t exp, output bus_word_t rdata);
        int n;
        @(posedge clk);
        psel      <= 1'b1;
        pwrite    <= wr;
        paddr     <= addr;
        pwdata    <= data;
        pstrb     <= strb;
        chk_mode  <= mode;
        exp_rdata <= exp;
        @(posedge clk);
        penable <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!pready_o && n < LIMIT);
        if (!pready_o) report_timeout("pready_o");
        rdata = prdata_o;
        @(posedge clk);
        psel     <= 1'b0;
        penable  <= 1'b0;
        chk_mode <= CHK_NONE;
    endtask

    task automatic apb_write(input apb_addr_t addr, input bus_word_t data, input byte_strb_t strb);
        bus_word_t unused;
        apb_xfer(1'b1, addr, data, strb, CHK_NONE, '0, unused);
    endtask

    task automatic apb_read_expect(input apb_addr_t addr, input bus_word_t exp);
        bus_word_t unused;
        apb_xfer(1'b0, addr, '0, '0, CHK_EQ, exp, unused);
    endtask

    initial begin
        bus_word_t  d;
        bus_word_t  last;
        bus_word_t  loaded;
        apb_addr_t  a;
        byte_strb_t s;
        int         n;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pstrb = '0;
        gpio_in = '0;
        m_out = '0;
        m_dir = '0;
        exp_rdata = '0;
        avoid_rdata = '0;
        chk_mode = CHK_NONE;
        irq_chk = 1'b1; // irq stays low until the compare test.
        rng = 32'd14;
        mism_cnt = 0;
        tmo_cnt = 0;
        n = 0;
        while (!rst_n && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!rst_n) report_timeout("reset release");

        repeat (8) begin
            rng = xorshift32(rng);
            a = rng[0] ? DIR_A : OUT_A;
            s = rng[7:4];
            rng = xorshift32(rng);
            apb_write(a, rng, s);
            d = apply_strobes(a == OUT_A ? m_out : m_dir, rng, s);
            if (a == OUT_A) m_out <= d;
            else            m_dir <= d;
            apb_read_expect(a, d);
        end

        rng = xorshift32(rng);
        @(posedge clk);
        gpio_in <= rng;
        repeat (3) @(posedge clk);
        apb_read_expect(IN_A, rng);
        d = rng;
        rng = xorshift32(rng);
        apb_write(IN_A, rng, 4'hF);
        apb_read_expect(IN_A, d);

        // ##########################################################
        // timer
        // ##########################################################
        rng = xorshift32(rng);
        loaded = rng & 32'h0FFF_FFFF; // far from the wrap, so compare at zero stays quiet.
        apb_write(COUNT_A, loaded, 4'hF);
        apb_read_expect(COUNT_A, loaded);
        avoid_rdata <= loaded;
        apb_write(CTRL_A, 32'h1, 4'hF);
        repeat (2 * `PB_TICK_DIV) @(posedge clk);
        last = loaded;
        repeat (4) begin
            apb_xfer(1'b0, COUNT_A, '0, '0, CHK_UP, last, d);
            last = d;
        end

        apb_write(CTRL_A, 32'h0, 4'hF);
        apb_write(COUNT_A, 32'h0, 4'hF);
        apb_write(CMP_A, 32'd5, 4'hF);
        apb_write(STAT_A, 32'h1, 4'hF);
        irq_chk <= 1'b0;
        apb_write(CTRL_A, 32'h1, 4'hF);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!irq_o && n < LIMIT);
        if (!irq_o) report_timeout("irq_o to rise");
        apb_read_expect(STAT_A, 32'h1);

        // unmapped accesses hit live register offsets while the hit flag is still set.
        apb_write(CTRL_A, 32'h0, 4'hF);
        rng = xorshift32(rng);
        loaded = rng;
        apb_write(COUNT_A, loaded, 4'hF);
        rng = xorshift32(rng);
        apb_write(12'h200, rng, 4'hF);
        apb_write(12'h304, ~rng, 4'hF);
        apb_write(12'hF08, 32'h1, 4'hF);
        apb_write(12'h50C, 32'h1, 4'hF);
        apb_xfer(1'b0, 12'h300, '0, '0, CHK_NONE, '0, d);
        apb_read_expect(OUT_A, m_out);
        apb_read_expect(DIR_A, m_dir);
        apb_read_expect(COUNT_A, loaded);
        apb_read_expect(CMP_A, 32'd5);
        apb_read_expect(CTRL_A, 32'h0);
        apb_read_expect(STAT_A, 32'h1);

        apb_write(STAT_A, 32'h1, 4'h1);
        apb_read_expect(STAT_A, 32'h0);
        irq_chk <= 1'b1; // irq has had a cycle to follow the cleared flag.

        @(posedge clk);
        $display("Summary: %0d mismatches, %0d timeouts", mism_cnt, tmo_cnt);
        if (mism_cnt + tmo_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== periph_bus.f ====
+incdir+design
design/periph_bus_pkg.sv
design/periph_apb_decode.sv
design/gpio_regs.sv
design/tick_timer.sv
design/periph_bus_top.sv
dv/tb_clk_gen.sv
dv/tb_periph_bus.sv
